//--- hw/stackPkg.sv
package stackPkg;

    localparam int boardRows = 20;
    localparam int boardCols = 10;
    localparam int countW = 16;

    typedef logic [boardCols-1:0] rowT;
    typedef rowT [boardRows-1:0] boardT; // Row 0 is the top row

    typedef enum logic [2:0] {
        line   = 3'd0,
        square = 3'd1,
        ell    = 3'd2,
        revEll = 3'd3,
        sKind  = 3'd4,
        zKind  = 3'd5,
        tKind  = 3'd6
    } pieceKindT;

    typedef struct packed {
        logic      active;
        pieceKindT kind;
        logic [4:0] y; // Top row of the piece
    } pieceStateT;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;
        logic [31:0] dat;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wbRspT;

    localparam logic [5:0] adrCtrl = 6'd0;
    localparam logic [5:0] adrLines = 6'd1;
    localparam logic [5:0] adrRowBase = 6'd32;

    localparam int cmdKindLsb = 0;
    localparam int cmdSpawn = 4;
    localparam int cmdStep = 5;
    localparam int cmdClear = 6;

    localparam int stActive = 0;
    localparam int stGameOver = 1;
    localparam int stKindLsb = 4;
    localparam int stYLsb = 8;

endpackage

//--- hw/pieceShape.sv
`timescale 1ns/1ps

module pieceShape (
    input  stackPkg::pieceKindT kind,
    input  logic [4:0]          top,
    output stackPkg::boardT     mask,
    output logic                fits
);

    stackPkg::rowT [3:0] pat; // Up to four rows, pat[0] lands on top
    stackPkg::boardT wide;
    logic [5:0] height;

    // Row bits are columns, bit 4 is column 4
    always_comb begin
        pat = '0;
        height = 6'd0;
        case (kind)
            stackPkg::line: begin
                pat[0] = 10'h010;
                pat[1] = 10'h010;
                pat[2] = 10'h010;
                pat[3] = 10'h010;
                height = 6'd4;
            end
            stackPkg::square: begin
                pat[0] = 10'h030;
                pat[1] = 10'h030;
                height = 6'd2;
            end
            stackPkg::ell: begin
                pat[0] = 10'h010;
                pat[1] = 10'h010;
                pat[2] = 10'h030; // Foot to the right
                height = 6'd3;
            end
            stackPkg::revEll: begin
                pat[0] = 10'h020;
                pat[1] = 10'h020;
                pat[2] = 10'h030; // Foot to the left
                height = 6'd3;
            end
            stackPkg::sKind: begin
                pat[0] = 10'h060;
                pat[1] = 10'h030;
                height = 6'd2;
            end
            stackPkg::zKind: begin
                pat[0] = 10'h030;
                pat[1] = 10'h060;
                height = 6'd2;
            end
            stackPkg::tKind: begin
                pat[0] = 10'h010;
                pat[1] = 10'h038;
                height = 6'd2;
            end
            default: begin
                pat = '0;
                height = 6'd0; // No piece
            end
        endcase
    end

    assign fits = (height != 6'd0) && ({1'b0, top} + height <= 6'(stackPkg::boardRows));

    always_comb begin
        wide = '0;
        wide[3:0] = pat;
        mask = '0;
        if (fits) begin
            mask = wide << (top * stackPkg::boardCols);
        end
    end

endmodule

//--- hw/pieceDropper.sv
`timescale 1ns/1ps

module pieceDropper (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 spawnPulse,
    input  logic                 stepPulse,
    input  logic                 clearPulse,
    input  stackPkg::pieceKindT  spawnKind,
    input  stackPkg::boardT      stack,
    input  stackPkg::boardT      spawnMask,
    input  stackPkg::boardT      nextMask,
    input  logic                 nextValid,
    output stackPkg::pieceStateT piece,
    output logic                 gameOver,
    output logic                 lockPulse
);

    stackPkg::pieceStateT state;
    logic kindOk;
    logic spawnTry;
    logic spawnBlocked;
    logic nextBlocked;
    logic canFall;

    assign kindOk = spawnKind <= stackPkg::tKind; // Code 7 spawns nothing
    assign spawnTry = spawnPulse && kindOk && !state.active && !gameOver;
    assign spawnBlocked = |(spawnMask & stack);
    assign nextBlocked = |(nextMask & stack);
    assign canFall = nextValid && !nextBlocked;

    // Shape select, points the shared shape table at the entry row during a spawn
    always_comb begin
        piece = state;
        if (spawnTry) begin
            piece.kind = spawnKind;
            piece.y = 5'd0;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= '0;
            gameOver <= 1'b0;
            lockPulse <= 1'b0;
        end else begin
            lockPulse <= 1'b0;
            if (clearPulse) begin
                state <= '0;
                gameOver <= 1'b0;
            end else if (spawnTry) begin
                if (spawnBlocked) begin
                    gameOver <= 1'b1; // Entry row already taken
                end else begin
                    state.active <= 1'b1;
                    state.kind <= spawnKind;
                    state.y <= 5'd0;
                end
            end else if (stepPulse && state.active) begin
                if (canFall) begin
                    state.y <= state.y + 5'd1;
                end else begin
                    state.active <= 1'b0; // Kind and y stay for the merge
                    lockPulse <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hw/stackBoard.sv
`timescale 1ns/1ps

module stackBoard (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        lockPulse,
    input  logic                        clearPulse,
    input  stackPkg::boardT             curMask,
    output stackPkg::boardT             stack,
    output logic [stackPkg::countW-1:0] lineCount
);

    stackPkg::boardT merged;
    stackPkg::boardT compact;
    logic [4:0] removed;
    int dst;

    // Walk up from the floor, copying rows that are not full
    always_comb begin
        merged = stack | curMask;
        compact = '0;
        removed = 5'd0;
        dst = stackPkg::boardRows - 1;
        for (int r = stackPkg::boardRows - 1; r >= 0; r--) begin
            if (&merged[r]) begin
                removed = removed + 5'd1;
            end else begin
                compact[dst] = merged[r];
                dst = dst - 1;
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            stack <= '0;
            lineCount <= '0;
        end else if (clearPulse) begin
            stack <= '0;
            lineCount <= '0;
        end else if (lockPulse) begin
            stack <= compact; // Empty rows fill in from the top
            lineCount <= lineCount + stackPkg::countW'(removed);
        end
    end

endmodule

//--- hw/wbRegs.sv
`timescale 1ns/1ps

module wbRegs (
    input  logic                        clk,
    input  logic                        rst,
    input  stackPkg::wbReqT             wb,
    output stackPkg::wbRspT             wbRsp,
    input  stackPkg::pieceStateT        piece,
    input  logic                        gameOver,
    input  stackPkg::boardT             curMask,
    input  stackPkg::boardT             stack,
    input  logic [stackPkg::countW-1:0] lineCount,
    output logic                        spawnPulse,
    output logic                        stepPulse,
    output logic                        clearPulse,
    output stackPkg::pieceKindT         spawnKind
);

    logic ack;
    logic [31:0] datR;
    logic [31:0] rdData;
    logic wrCtrl;
    logic [5:0] rowOfs;
    logic [4:0] rowIdx;
    logic rowHit;

    assign wrCtrl = ack && wb.cyc && wb.stb && wb.we && (wb.adr == stackPkg::adrCtrl);

    // Clear beats spawn, spawn beats step
    assign clearPulse = wrCtrl && wb.dat[stackPkg::cmdClear];
    assign spawnPulse = wrCtrl && wb.dat[stackPkg::cmdSpawn] && !wb.dat[stackPkg::cmdClear];
    assign stepPulse = wrCtrl && wb.dat[stackPkg::cmdStep] && !wb.dat[stackPkg::cmdSpawn]
                       && !wb.dat[stackPkg::cmdClear];
    assign spawnKind = stackPkg::pieceKindT'(wb.dat[stackPkg::cmdKindLsb +: 3]);

    assign rowOfs = wb.adr - stackPkg::adrRowBase;
    assign rowIdx = rowOfs[4:0];
    assign rowHit = (wb.adr >= stackPkg::adrRowBase)
                    && (rowOfs < 6'(stackPkg::boardRows));

    always_comb begin
        rdData = '0;
        if (wb.adr == stackPkg::adrCtrl) begin
            rdData[stackPkg::stActive] = piece.active;
            rdData[stackPkg::stGameOver] = gameOver;
            rdData[stackPkg::stKindLsb +: 3] = piece.kind;
            rdData[stackPkg::stYLsb +: 5] = piece.y;
        end else if (wb.adr == stackPkg::adrLines) begin
            rdData[stackPkg::countW-1:0] = lineCount;
        end else if (rowHit) begin
            rdData[stackPkg::boardCols-1:0] = stack[rowIdx]; // Displayed row
            if (piece.active) begin
                rdData[stackPkg::boardCols-1:0] = stack[rowIdx] | curMask[rowIdx];
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            ack <= wb.cyc && wb.stb && !ack; // One wait cycle, then ack
        end
    end

    always_ff @(posedge clk) begin
        datR <= rdData;
    end

    assign wbRsp.ack = ack;
    assign wbRsp.dat = datR;

endmodule

//--- hw/stackCore.sv
`timescale 1ns/1ps

module stackCore (
    input  logic            clk,
    input  logic            rst,
    input  stackPkg::wbReqT wb,
    output stackPkg::wbRspT wbRsp
);

    stackPkg::pieceStateT piece;
    stackPkg::pieceKindT spawnKind;
    stackPkg::boardT curMask;
    stackPkg::boardT nextMask;
    stackPkg::boardT stack;
    logic [stackPkg::countW-1:0] lineCount;
    logic spawnPulse;
    logic stepPulse;
    logic clearPulse;
    logic lockPulse;
    logic gameOver;
    logic nextValid;

    wbRegs regsInst (
        .clk(clk), .rst(rst), .wb(wb), .wbRsp(wbRsp),
        .piece(piece), .gameOver(gameOver), .curMask(curMask), .stack(stack),
        .lineCount(lineCount), .spawnPulse(spawnPulse), .stepPulse(stepPulse),
        .clearPulse(clearPulse), .spawnKind(spawnKind)
    );

    pieceDropper dropperInst (
        .clk(clk), .rst(rst), .spawnPulse(spawnPulse), .stepPulse(stepPulse),
        .clearPulse(clearPulse), .spawnKind(spawnKind), .stack(stack),
        .spawnMask(curMask), .nextMask(nextMask), .nextValid(nextValid),
        .piece(piece), .gameOver(gameOver), .lockPulse(lockPulse)
    );

    pieceShape shapeCurInst (.kind(piece.kind), .top(piece.y), .mask(curMask), .fits());

    pieceShape shapeNextInst (
        .kind(piece.kind), .top(piece.y + 5'd1), .mask(nextMask), .fits(nextValid)
    );

    stackBoard boardInst (
        .clk(clk), .rst(rst), .lockPulse(lockPulse), .clearPulse(clearPulse),
        .curMask(curMask), .stack(stack), .lineCount(lineCount)
    );

endmodule

//--- tb/stackModel.sv
package stackModel;

    logic [9:0] board[20]; // Settled cells, row 0 on top
    bit active;
    bit gameOver;
    int kind;
    int y;
    int lines;

    // Row offset of cell i in the reference layout
    function automatic int cellRow(input int k, input int i);
        int rows[4];
        case (k)
            0: rows = '{0, 1, 2, 3};
            2, 3: rows = '{0, 1, 2, 2};
            6: rows = '{0, 1, 1, 1};
            default: rows = '{0, 0, 1, 1};
        endcase
        return rows[i];
    endfunction

    function automatic int cellCol(input int k, input int i);
        int cols[4];
        case (k)
            0: cols = '{4, 4, 4, 4};
            1: cols = '{4, 5, 4, 5};
            2: cols = '{4, 4, 4, 5};
            3: cols = '{5, 5, 4, 5};
            4: cols = '{5, 6, 4, 5};
            5: cols = '{4, 5, 5, 6};
            default: cols = '{4, 3, 4, 5};
        endcase
        return cols[i];
    endfunction

    function automatic bit placeOk(input int k, input int top);
        int r;
        for (int i = 0; i < 4; i++) begin
            r = top + cellRow(k, i);
            if (r > 19 || board[r][cellCol(k, i)]) begin
                return 0;
            end
        end
        return 1;
    endfunction

    function automatic logic [9:0] shownRow(input int r);
        logic [9:0] bits;
        bits = board[r];
        for (int i = 0; i < 4; i++) begin
            if (active && y + cellRow(kind, i) == r) begin
                bits[cellCol(kind, i)] = 1'b1;
            end
        end
        return bits;
    endfunction

    function automatic void lockPiece();
        for (int i = 0; i < 4; i++) begin
            board[y + cellRow(kind, i)][cellCol(kind, i)] = 1'b1;
        end
        for (int r = 19; r >= 0; r--) begin
            while (board[r] == 10'h3ff) begin
                lines++;
                for (int s = r; s > 0; s--) begin
                    board[s] = board[s - 1]; // Everything above drops one row
                end
                board[0] = '0;
            end
        end
    endfunction

    function automatic void spawn(input int k);
        if (active || gameOver || k > 6) begin
            return;
        end
        if (placeOk(k, 0)) begin
            active = 1;
            kind = k;
            y = 0;
        end else begin
            gameOver = 1;
        end
    endfunction

    function automatic void step();
        if (!active) begin
            return;
        end
        if (placeOk(kind, y + 1)) begin
            y++;
        end else begin
            active = 0;
            lockPiece();
        end
    endfunction

    function automatic void clear();
        foreach (board[r]) begin
            board[r] = '0;
        end
        active = 0;
        gameOver = 0;
        kind = 0;
        y = 0;
        lines = 0;
    endfunction

    function automatic logic [31:0] status();
        logic [31:0] st;
        st = '0;
        st[0] = active;
        st[1] = gameOver;
        st[6:4] = 3'(kind);
        st[12:8] = 5'(y); // Last piece stays visible after a lock
        return st;
    endfunction

endpackage

//--- tb/stackTb.sv
`timescale 1ns/1ps

module stackTb;

    localparam int resetCycles = 16;
    localparam int dropPieces = 6;
    localparam int seqPieces = 10;
    localparam int maxPieces = 30;
    localparam int perPiece = 66; // Spawn, up to 20 steps with status reads, board read
    localparam int cmdBudget = 22 * 3 + 7 * 48 + (dropPieces + seqPieces + maxPieces) * perPiece;
    localparam int watchdogCycles = 40 * cmdBudget + resetCycles + 200;

    logic clk;
    logic rst;
    stackPkg::wbReqT wb;
    stackPkg::wbRspT wbRsp;
    int errors;
    int checks;
    int tests;
    int testStart;

    stackCore stackCore_inst (.clk(clk), .rst(rst), .wb(wb), .wbRsp(wbRsp));

    always #10 clk = ~clk;

    task automatic busCycle(input logic we, input logic [5:0] adr, input logic [31:0] dat,
                            output logic [31:0] data);
        stackPkg::wbReqT req;
        int waits;
        req = '0;
        req.cyc = 1'b1;
        req.stb = 1'b1;
        req.we = we;
        req.adr = adr;
        req.dat = dat;
        waits = 0;
        @(posedge clk);
        wb <= req;
        do begin
            @(negedge clk);
            waits++;
        end while (!wbRsp.ack);
        data = wbRsp.dat;
        checks++;
        assert (waits == 2) else begin
            $display("Ack came %0d cycles after the strobe instead of 2", waits);
            errors++;
        end
        @(posedge clk);
        wb <= '0; // Idle again after the ack cycle
        @(negedge clk);
        expectEq("ack", 32'(wbRsp.ack), 32'h0); // Held for one cycle only
    endtask

    task automatic wbWrite(input logic [5:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        busCycle(1'b1, adr, dat, ignored);
    endtask

    task automatic wbRead(input logic [5:0] adr, output logic [31:0] data);
        busCycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic sendCommand(input int bitPos, input int k);
        logic [31:0] cmd;
        cmd = '0;
        cmd[bitPos] = 1'b1;
        cmd[2:0] = 3'(k);
        wbWrite(stackPkg::adrCtrl, cmd);
    endtask

    task automatic spawnPiece(input int k);
        sendCommand(stackPkg::cmdSpawn, k);
        stackModel::spawn(k);
    endtask

    task automatic stepPiece();
        sendCommand(stackPkg::cmdStep, 0);
        stackModel::step();
    endtask

    task automatic clearGame();
        sendCommand(stackPkg::cmdClear, 0);
        stackModel::clear();
    endtask

    task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0d ns: %s read %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic verifyStatus();
        logic [31:0] data;
        wbRead(stackPkg::adrCtrl, data);
        expectEq("status", data, stackModel::status());
    endtask

    task automatic compareBoard();
        logic [31:0] data;
        verifyStatus();
        wbRead(stackPkg::adrLines, data);
        expectEq("lineCount", data, 32'(stackModel::lines));
        for (int r = 0; r < stackPkg::boardRows; r++) begin
            wbRead(stackPkg::adrRowBase + 6'(r), data);
            expectEq($sformatf("row%0d", r), data, 32'(stackModel::shownRow(r)));
        end
    endtask

    task automatic dropPiece(input int k);
        spawnPiece(k);
        verifyStatus();
        while (stackModel::active) begin
            stepPiece();
            verifyStatus(); // y advances or the piece locks
        end
        compareBoard();
    endtask

    task automatic finishTest(input string name);
        tests++;
        $display("Test %-10s %0d errors", name, errors - testStart);
        testStart = errors;
    endtask

    initial begin
        void'($urandom(32'h9c412dc6));
        clk = 1'b0;
        rst = 1'b1;
        wb = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        testStart = 0;
        stackModel::clear();
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;

        compareBoard();
        finishTest("reset");

        for (int k = 0; k < 7; k++) begin
            clearGame();
            spawnPiece(k);
            compareBoard();
            spawnPiece(int'($urandom_range(7, 0))); // Ignored while active
            compareBoard();
        end
        finishTest("spawn");

        clearGame();
        repeat (dropPieces) begin
            dropPiece(int'($urandom_range(6, 0)));
            stepPiece();
            verifyStatus();
        end
        finishTest("drop");

        clearGame();
        repeat (seqPieces) begin
            if (stackModel::gameOver) begin
                clearGame();
            end
            dropPiece(int'($urandom_range(7, 0))); // Code 7 spawns nothing
        end
        finishTest("lines");

        clearGame();
        for (int n = 0; n < maxPieces && !stackModel::gameOver; n++) begin
            dropPiece(int'($urandom_range(6, 0)));
        end
        assert (stackModel::gameOver) else begin
            $display("The stack never blocked a spawn within %0d pieces", maxPieces);
            errors++;
        end
        spawnPiece(int'($urandom_range(6, 0)));
        compareBoard();
        clearGame();
        compareBoard();
        finishTest("gameOver");

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not complete", watchdogCycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- build.f
hw/stackPkg.sv
hw/pieceShape.sv
hw/pieceDropper.sv
hw/stackBoard.sv
hw/wbRegs.sv
hw/stackCore.sv
tb/stackModel.sv
tb/stackTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f build.f --top-module stackTb -o stackSim
./obj_dir/stackSim > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0
